/* hdl/tag_rt_pkg.sv */
package tag_rt_pkg;

    ////////////////////////////////////////////////////
    // Word format
    ////////////////////////////////////////////////////

    localparam int N_TAG = 8;         // Tag bits.
    localparam int N_RT = 5;          // Real-time bits.
    localparam int SEL_W = 3;         // Address and gate fields.
    localparam int TLM_SPARE_W = 10;
    localparam int PROC_SPARE_W = 3;

    ////////////////////////////////////////////////////
    // Word time
    ////////////////////////////////////////////////////

    localparam int CNT_W = 3;
    localparam int N_PHASE = 6;               // Phases per command.
    localparam int PH_V1 = 1;                 // Clear and discrete phase.
    localparam int PH_SET_TLM = 4;            // Telemetry set phase.
    localparam int PH_SET_PROC = N_PHASE;     // Processor set phase, last.

    // Gate codes that raise the discrete pulses.
    localparam int ADI_GATE = 2;
    localparam int BDI_GATE = 1;

    ////////////////////////////////////////////////////
    // Command word
    ////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        KIND_NOP  = 2'd0,
        KIND_TLM  = 2'd1,     // Telemetry.
        KIND_PROC = 2'd2,     // Processor.
        KIND_CLR  = 2'd3      // Clear, bank chosen by tgt.
    } cmd_kind_e;

    // Telemetry and clear words use the tlm view, processor words the proc view.
    typedef union packed {
        struct packed {
            cmd_kind_e               kind;
            logic                    tgt;     // 0 tag bank, 1 real-time bank.
            logic [SEL_W-1:0]        addr;
            logic [TLM_SPARE_W-1:0]  spare;
        } tlm;
        struct packed {
            cmd_kind_e               kind;
            logic [SEL_W-1:0]        gate_a;
            logic [SEL_W-1:0]        gate_b;
            logic                    ltr;
            logic                    info;
            logic                    tcw;
            logic                    paa;
            logic                    pba;
            logic [PROC_SPARE_W-1:0] spare;
        } proc;
    } cmd_word_u;

endpackage

/* hdl/tag_decode_if.sv */
`timescale 1ns/100ps

interface tag_decode_if;

    import tag_rt_pkg::*;

    logic             is_tlm;
    logic             is_proc;
    logic             clr_tag;
    logic             clr_rt;
    logic [N_TAG-1:0] tlm_tag_sel;
    logic [N_RT-1:0]  tlm_rt_sel;
    logic             proc_qual;      // ltr, info, tcw and paa all set.
    logic [N_TAG-1:0] gate_a_sel;
    logic [N_RT-1:0]  gate_b_sel;
    logic             adi_req;
    logic             bdi_req;

    modport dec (
        output is_tlm, is_proc,
        output clr_tag, clr_rt,
        output tlm_tag_sel, tlm_rt_sel,
        output proc_qual, gate_a_sel, gate_b_sel,
        output adi_req, bdi_req
    );

    modport bank (
        input is_tlm, is_proc,
        input clr_tag, clr_rt,
        input tlm_tag_sel, tlm_rt_sel,
        input proc_qual, gate_a_sel, gate_b_sel,
        input adi_req, bdi_req
    );

endinterface

/* hdl/word_sequencer.sv */
`timescale 1ns/100ps

module word_sequencer (
    input  logic                  sim_clk,
    input  logic                  rst_n,
    input  logic                  cmd_strobe,
    input  tag_rt_pkg::cmd_word_u cmd_word,
    output tag_rt_pkg::cmd_word_u cur_word,
    output logic                  ph_v1,
    output logic                  ph_set_tlm,
    output logic                  ph_set_proc,
    output logic                  busy,
    output logic                  done
);

    import tag_rt_pkg::*;

    logic [CNT_W-1:0] phase_cnt;      // 0 idle, 1..N_PHASE in word time.
    logic             accept;
    logic             last_phase;

    ////////////////////////////////////////////////////
    // Acceptance and phase counter
    ////////////////////////////////////////////////////

    assign accept = cmd_strobe && (phase_cnt == '0);
    assign last_phase = (phase_cnt == CNT_W'(N_PHASE));

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            phase_cnt <= '0;
        end else if (accept) begin
            phase_cnt <= CNT_W'(1);
        end else if (last_phase) begin
            phase_cnt <= '0;                  // Back to idle.
        end else if (phase_cnt != '0) begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    // Word is held for the whole word time.
    always_ff @(posedge sim_clk) begin
        if (accept) begin
            cur_word <= cmd_word;
        end
    end

    ////////////////////////////////////////////////////
    // Phase strobes
    ////////////////////////////////////////////////////

    assign busy        = (phase_cnt != '0);
    assign ph_v1       = (phase_cnt == CNT_W'(PH_V1));
    assign ph_set_tlm  = (phase_cnt == CNT_W'(PH_SET_TLM));
    assign ph_set_proc = (phase_cnt == CNT_W'(PH_SET_PROC));
    assign done        = last_phase;          // Same cycle as ph_set_proc.

endmodule

/* hdl/cmd_decoder.sv */
`timescale 1ns/100ps

module cmd_decoder (
    input  tag_rt_pkg::cmd_word_u cur_word,
    tag_decode_if.dec             dec
);

    import tag_rt_pkg::*;

    cmd_kind_e        kind;
    logic             tgt;
    logic [SEL_W-1:0] addr;
    logic [SEL_W-1:0] gate_a;
    logic [SEL_W-1:0] gate_b;

    ////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////

    assign kind   = cur_word.tlm.kind;      // Shared by both views.
    assign tgt    = cur_word.tlm.tgt;
    assign addr   = cur_word.tlm.addr;
    assign gate_a = cur_word.proc.gate_a;
    assign gate_b = cur_word.proc.gate_b;

    ////////////////////////////////////////////////////
    // Mode levels and clears
    ////////////////////////////////////////////////////

    always_comb begin
        dec.is_tlm  = (kind == KIND_TLM);
        dec.is_proc = (kind == KIND_PROC);
        dec.clr_tag = (kind == KIND_CLR) && !tgt;
        dec.clr_rt  = (kind == KIND_CLR) && tgt;
    end

    ////////////////////////////////////////////////////
    // One-hot selections
    ////////////////////////////////////////////////////

    // Telemetry address, steered by tgt.
    always_comb begin
        dec.tlm_tag_sel = '0;
        dec.tlm_rt_sel  = '0;
        if (!tgt) begin
            dec.tlm_tag_sel = N_TAG'(1) << addr;
        end else if (addr < N_RT) begin
            dec.tlm_rt_sel = N_RT'(1) << addr;    // Codes 5..7 select nothing.
        end
    end

    // Processor gates.
    always_comb begin
        dec.gate_a_sel = N_TAG'(1) << gate_a;
        dec.gate_b_sel = '0;
        if (gate_b < N_RT) begin
            dec.gate_b_sel = N_RT'(1) << gate_b;
        end
    end

    ////////////////////////////////////////////////////
    // Qualifier and discrete requests
    ////////////////////////////////////////////////////

    always_comb begin
        dec.proc_qual = cur_word.proc.ltr & cur_word.proc.info &
                        cur_word.proc.tcw & cur_word.proc.paa;
        // Discretes ignore the qualifier.
        dec.adi_req = (kind == KIND_PROC) && cur_word.proc.paa &&
                      (gate_a == SEL_W'(ADI_GATE));
        dec.bdi_req = (kind == KIND_PROC) && cur_word.proc.pba &&
                      (gate_a == SEL_W'(BDI_GATE));
    end

endmodule

/* hdl/tag_register.sv */
`timescale 1ns/100ps

module tag_register (
    input  logic                         sim_clk,
    input  logic                         rst_n,
    input  logic                         ph_v1,
    input  logic                         ph_set_tlm,
    input  logic                         ph_set_proc,
    tag_decode_if.bank                   bank,
    output logic [tag_rt_pkg::N_TAG-1:0] tag
);

    import tag_rt_pkg::*;

    logic             clr_term;
    logic             tlm_en;
    logic             proc_en;
    logic [N_TAG-1:0] set_tlm;
    logic [N_TAG-1:0] set_proc;
    logic [N_TAG-1:0] set_term;

    ////////////////////////////////////////////////////
    // Set and clear terms
    ////////////////////////////////////////////////////

    assign clr_term = ph_v1 & bank.clr_tag;                 // Whole bank.
    assign tlm_en   = ph_set_tlm & bank.is_tlm;
    assign proc_en  = ph_set_proc & bank.is_proc & bank.proc_qual;

    assign set_tlm  = bank.tlm_tag_sel & {N_TAG{tlm_en}};
    assign set_proc = bank.gate_a_sel & {N_TAG{proc_en}};
    assign set_term = set_tlm | set_proc;

    ////////////////////////////////////////////////////
    // Tag latches
    ////////////////////////////////////////////////////

    // Each bit holds until the clear term, sets accumulate.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            tag <= '0;
        end else if (clr_term) begin
            tag <= '0;
        end else begin
            tag <= tag | set_term;
        end
    end

endmodule

/* hdl/rt_register.sv */
`timescale 1ns/100ps

module rt_register (
    input  logic                        sim_clk,
    input  logic                        rst_n,
    input  logic                        ph_v1,
    input  logic                        ph_set_tlm,
    input  logic                        ph_set_proc,
    tag_decode_if.bank                  bank,
    output logic [tag_rt_pkg::N_RT-1:0] rtr,
    output logic                        adi,
    output logic                        bdi
);

    import tag_rt_pkg::*;

    logic            clr_term;
    logic            tlm_en;
    logic            proc_en;
    logic [N_RT-1:0] set_tlm;
    logic [N_RT-1:0] set_proc;
    logic [N_RT-1:0] set_term;

    ////////////////////////////////////////////////////
    // Set and clear terms
    ////////////////////////////////////////////////////

    assign clr_term = ph_v1 & bank.clr_rt;
    assign tlm_en   = ph_set_tlm & bank.is_tlm;
    assign proc_en  = ph_set_proc & bank.is_proc & bank.proc_qual;

    assign set_tlm  = bank.tlm_rt_sel & {N_RT{tlm_en}};
    assign set_proc = bank.gate_b_sel & {N_RT{proc_en}};    // Gate B drives rtr.
    assign set_term = set_tlm | set_proc;

    ////////////////////////////////////////////////////
    // Real-time latches
    ////////////////////////////////////////////////////

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            rtr <= '0;
        end else if (clr_term) begin
            rtr <= '0;
        end else begin
            rtr <= rtr | set_term;
        end
    end

    ////////////////////////////////////////////////////
    // Discrete pulses
    ////////////////////////////////////////////////////

    // Sampled in phase 1, so high for the following cycle only.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            adi <= 1'b0;
            bdi <= 1'b0;
        end else begin
            adi <= ph_v1 & bank.adi_req;
            bdi <= ph_v1 & bank.bdi_req;
        end
    end

endmodule

/* hdl/tag_rt_top.sv */
`timescale 1ns/100ps

module tag_rt_top (
    input  logic                         sim_clk,
    input  logic                         rst_n,
    input  logic                         cmd_strobe,
    input  tag_rt_pkg::cmd_word_u        cmd_word,
    output logic                         busy,
    output logic                         done,
    output logic [tag_rt_pkg::N_TAG-1:0] tag,
    output logic [tag_rt_pkg::N_RT-1:0]  rtr,
    output logic                         adi,
    output logic                         bdi
);

    import tag_rt_pkg::*;

    cmd_word_u cur_word;
    logic      ph_v1;
    logic      ph_set_tlm;
    logic      ph_set_proc;

    tag_decode_if dec_if ();

    ////////////////////////////////////////////////////
    // Control and decode
    ////////////////////////////////////////////////////

    word_sequencer seq0 (
        .sim_clk     (sim_clk),
        .rst_n       (rst_n),
        .cmd_strobe  (cmd_strobe),
        .cmd_word    (cmd_word),
        .cur_word    (cur_word),
        .ph_v1       (ph_v1),
        .ph_set_tlm  (ph_set_tlm),
        .ph_set_proc (ph_set_proc),
        .busy        (busy),
        .done        (done)
    );

    cmd_decoder dec0 (
        .cur_word (cur_word),
        .dec      (dec_if.dec)
    );

    ////////////////////////////////////////////////////
    // Register banks
    ////////////////////////////////////////////////////

    tag_register tag0 (
        .sim_clk     (sim_clk),
        .rst_n       (rst_n),
        .ph_v1       (ph_v1),
        .ph_set_tlm  (ph_set_tlm),
        .ph_set_proc (ph_set_proc),
        .bank        (dec_if.bank),
        .tag         (tag)
    );

    rt_register rt0 (
        .sim_clk     (sim_clk),
        .rst_n       (rst_n),
        .ph_v1       (ph_v1),
        .ph_set_tlm  (ph_set_tlm),
        .ph_set_proc (ph_set_proc),
        .bank        (dec_if.bank),
        .rtr         (rtr),
        .adi         (adi),
        .bdi         (bdi)
    );

endmodule

/* sim/tb_tag_rt_tasks.svh */
`ifndef TB_TAG_RT_TASKS_SVH
`define TB_TAG_RT_TASKS_SVH

////////////////////////////////////////////////////
// Drive and wait
////////////////////////////////////////////////////

// One clock, landing just after the edge.
task automatic step();
    @(posedge sim_clk);
    #2;
endtask

task automatic send_cmd(input cmd_word_u w);
    int n;
    n = 0;
    while (busy && n < TIMEOUT) begin
        step();
        n++;
    end
    if (busy) begin
        $display("Timeout: busy never fell before a new command at %0t", $time);
        errors++;
    end
    cmd_strobe = 1'b1;
    cmd_word   = w;
    step();
    cmd_strobe = 1'b0;                        // Now in phase 1.
endtask

task automatic wait_done();
    int n;
    n = 0;
    while (!done && n < TIMEOUT) begin
        step();
        n++;
    end
    if (!done) begin
        $display("Timeout: done never rose at %0t", $time);
        errors++;
    end
endtask

////////////////////////////////////////////////////
// Compare
////////////////////////////////////////////////////

task automatic check_tag(input logic [N_TAG-1:0] got, input logic [N_TAG-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAILED tag: got %h, expected %h at %0t", got, exp, $time);
    end
endtask

task automatic check_rt(input logic [N_RT-1:0] got, input logic [N_RT-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAILED rtr: got %h, expected %h at %0t", got, exp, $time);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

`endif

/* sim/tb_tag_rt.sv */
`timescale 1ns/100ps

module tb_tag_rt;

    import tag_rt_pkg::*;

    localparam int TIMEOUT = 50;      // Cycles allowed per wait.
    localparam int N_RAND = 12;

    logic             sim_clk;
    logic             rst_n;
    logic             cmd_strobe;
    cmd_word_u        cmd_word;
    logic             busy;
    logic             done;
    logic [N_TAG-1:0] tag;
    logic [N_RT-1:0]  rtr;
    logic             adi;
    logic             bdi;

    logic [N_TAG-1:0] model_tag;
    logic [N_RT-1:0]  model_rtr;
    int               errors;
    int               checks;
    int               seed;

    tag_rt_top dut0 (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .cmd_strobe (cmd_strobe),
        .cmd_word   (cmd_word),
        .busy       (busy),
        .done       (done),
        .tag        (tag),
        .rtr        (rtr),
        .adi        (adi),
        .bdi        (bdi)
    );

    always #10 sim_clk = ~sim_clk;

    `include "tb_tag_rt_tasks.svh"

    ////////////////////////////////////////////////////
    // Word builders and model
    ////////////////////////////////////////////////////

    function automatic cmd_word_u make_tlm(input logic tgt, input logic [SEL_W-1:0] addr);
        cmd_word_u w;
        w = '0;
        w.tlm.kind  = KIND_TLM;
        w.tlm.tgt   = tgt;
        w.tlm.addr  = addr;
        w.tlm.spare = TLM_SPARE_W'($urandom);   // Spare bits are ignored.
        return w;
    endfunction

    function automatic cmd_word_u make_clr(input logic tgt);
        cmd_word_u w;
        w = cmd_word_u'(16'($urandom));
        w.tlm.kind = KIND_CLR;
        w.tlm.tgt  = tgt;
        return w;
    endfunction

    // Flags are {ltr, info, tcw, paa, pba}.
    function automatic cmd_word_u make_proc(input logic [SEL_W-1:0] ga,
                                            input logic [SEL_W-1:0] gb,
                                            input logic [4:0] flags);
        cmd_word_u w;
        w = '0;
        w.proc.kind   = KIND_PROC;
        w.proc.gate_a = ga;
        w.proc.gate_b = gb;
        {w.proc.ltr, w.proc.info, w.proc.tcw, w.proc.paa, w.proc.pba} = flags;
        return w;
    endfunction

    task automatic apply_rules(input cmd_word_u w);
        logic qual;
        qual = w.proc.ltr && w.proc.info && w.proc.tcw && w.proc.paa;
        case (w.tlm.kind)
            KIND_TLM: begin
                if (!w.tlm.tgt) begin
                    model_tag[w.tlm.addr] = 1'b1;
                end else if (w.tlm.addr < N_RT) begin
                    model_rtr[w.tlm.addr] = 1'b1;
                end
            end
            KIND_PROC: begin
                if (qual) begin
                    model_tag[w.proc.gate_a] = 1'b1;
                    if (w.proc.gate_b < N_RT) begin
                        model_rtr[w.proc.gate_b] = 1'b1;
                    end
                end
            end
            KIND_CLR: begin
                if (!w.tlm.tgt) begin
                    model_tag = '0;
                end else begin
                    model_rtr = '0;
                end
            end
            default: ;                        // NOP.
        endcase
    endtask

    task automatic run_cmd(input cmd_word_u w);
        send_cmd(w);
        apply_rules(w);
        wait_done();
        step();                               // Cycle after done.
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_tag(tag, model_tag);
        check_rt(rtr, model_rtr);
    endtask

    ////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////

    task automatic test_reset();
        check_tag(tag, '0);
        check_rt(rtr, '0);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("adi", adi, 1'b0);
        check_bit("bdi", bdi, 1'b0);
    endtask

    task automatic test_tlm_sets();
        run_cmd(make_tlm(1'b1, 3'd6));        // No real-time bit 6.
        run_cmd(make_tlm(1'b1, 3'd5));
        for (int i = 0; i < N_RAND; i++) begin
            run_cmd(make_tlm(1'($urandom), SEL_W'($urandom)));
        end
    endtask

    task automatic test_proc();
        cmd_word_u  w;
        cmd_word_u  u;
        logic [4:0] flags;
        for (int i = 0; i < N_RAND; i++) begin
            run_cmd(make_clr(1'b0));
            run_cmd(make_clr(1'b1));
            flags = 5'b11110 | 5'($urandom % 2);
            w = make_proc(SEL_W'($urandom), SEL_W'($urandom), flags);
            // Same word with one of ltr, info, tcw, paa dropped.
            u = make_proc(w.proc.gate_a, w.proc.gate_b,
                          flags & ~(5'b00010 << ($urandom % 4)));
            run_cmd(u);
            run_cmd(w);
        end
    endtask

    task automatic test_clear();
        cmd_word_u w;
        run_cmd(make_tlm(1'b0, 3'd5));
        run_cmd(make_tlm(1'b1, 3'd3));
        w = cmd_word_u'(16'($urandom));
        w.tlm.kind = KIND_NOP;
        run_cmd(w);
        run_cmd(make_clr(1'b0));              // Tags only.
        run_cmd(make_tlm(1'b0, 3'd1));
        run_cmd(make_clr(1'b1));              // Real-time only.
    endtask

    task automatic pulse_cmd(input cmd_word_u w);
        logic exp_adi;
        logic exp_bdi;
        exp_adi = (w.proc.kind == KIND_PROC) && w.proc.paa && (w.proc.gate_a == 3'd2);
        exp_bdi = (w.proc.kind == KIND_PROC) && w.proc.pba && (w.proc.gate_a == 3'd1);
        send_cmd(w);
        apply_rules(w);
        check_bit("adi", adi, 1'b0);
        check_bit("bdi", bdi, 1'b0);
        step();                               // Cycle 2.
        check_bit("adi", adi, exp_adi);
        check_bit("bdi", bdi, exp_bdi);
        step();
        check_bit("adi", adi, 1'b0);
        check_bit("bdi", bdi, 1'b0);
        wait_done();
        step();
        check_tag(tag, model_tag);
        check_rt(rtr, model_rtr);
    endtask

    task automatic test_pulses();
        cmd_word_u w;
        pulse_cmd(make_proc(3'd2, 3'd0, 5'b00010));
        pulse_cmd(make_proc(3'd1, 3'd4, 5'b00001));
        pulse_cmd(make_proc(3'd2, 3'd3, 5'b00001));
        pulse_cmd(make_proc(3'd1, 3'd0, 5'b11110));
        pulse_cmd(make_proc(3'd2, 3'd1, 5'b11111));
        // Telemetry word whose proc view reads as an adi match.
        w = make_tlm(1'b0, 3'b100);
        w.tlm.spare = '1;
        pulse_cmd(w);
    endtask

    task automatic test_backpressure();
        cmd_word_u first;
        cmd_word_u second;
        run_cmd(make_clr(1'b0));
        run_cmd(make_clr(1'b1));
        first  = make_tlm(1'b0, 3'd3);
        second = make_tlm(1'b1, 3'd2);
        send_cmd(first);
        apply_rules(first);
        cmd_strobe = 1'b1;                    // Dropped, word time running.
        cmd_word   = second;
        step();
        cmd_strobe = 1'b0;
        check_bit("busy", busy, 1'b1);
        wait_done();
        cmd_strobe = 1'b1;                    // Dropped in the done cycle too.
        step();
        cmd_strobe = 1'b0;
        check_tag(tag, model_tag);
        check_rt(rtr, model_rtr);
        step();
        check_bit("busy", busy, 1'b0);
    endtask

    initial begin
        sim_clk    = 1'b0;
        rst_n      = 1'b0;
        cmd_strobe = 1'b0;
        cmd_word   = '0;
        model_tag  = '0;
        model_rtr  = '0;
        errors     = 0;
        checks     = 0;
        seed       = $urandom(32'h5bfa);
        repeat (5) @(posedge sim_clk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_tlm_sets();
        test_proc();
        test_clear();
        test_pulses();
        test_backpressure();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* tag_rt_top.f */
+incdir+sim
hdl/tag_rt_pkg.sv
hdl/tag_decode_if.sv
hdl/word_sequencer.sv
hdl/cmd_decoder.sv
hdl/tag_register.sv
hdl/rt_register.sv
hdl/tag_rt_top.sv
sim/tb_tag_rt.sv
